/* hw/mem_bridge_cfg.svh */
// Width, bank count, burst limit and response latency macros for the memory bridge.
`ifndef MEM_BRIDGE_CFG_SVH
`define MEM_BRIDGE_CFG_SVH

// Byte address width of the command and bank ports.
`define MB_ADDR_W 16

// Word width of one bank, which is also the width of one beat.
`define MB_DATA_W 32

// Number of interleaved banks.
// Consecutive words go to consecutive banks.
`define MB_NUM_BANKS 2

// Largest number of beats in one burst command.
`define MB_MAX_BEATS 16

// Fixed bank latency in cycles from grant to rvalid.
// The route FIFO in each arbiter holds one more entry than this.
`define MB_RESP_DEPTH 1

`endif

/* hw/mem_bridge_pkg.sv */
// Shared vector typedefs and the burst sequencer state type for the memory bridge.
`include "mem_bridge_cfg.svh"
`default_nettype none

package mem_bridge_pkg;

  // Byte address as seen on the command and bank ports.
  typedef logic [`MB_ADDR_W-1:0] addr_t;

  // One bank word, which is one beat of a burst.
  typedef logic [`MB_DATA_W-1:0] data_t;

  // Byte enables, one bit per byte of a word.
  typedef logic [`MB_DATA_W/8-1:0] strb_t;

  // Beat count wide enough to hold the largest burst length itself.
  typedef logic [$clog2(`MB_MAX_BEATS+1)-1:0] beats_t;

  // Bank index taken from the low bits of the word address.
  typedef logic [$clog2(`MB_NUM_BANKS)-1:0] bank_sel_t;

  // Sequencer states.
  // ISSUE sends beats to the banks and DRAIN waits for the last responses.
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN
  } seq_state_e;

endpackage

`default_nettype wire

/* hw/beat_counter.sv */
// Beat counter that tracks issued beats and outstanding responses of one burst.
`include "mem_bridge_cfg.svh"
`timescale 1ns/1ns
`default_nettype none

module beat_counter (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   load_i,
  input  mem_bridge_pkg::beats_t beats_i,
  input  logic                   issue_i,
  input  logic                   return_i,
  output logic                   last_issue_o,
  output logic                   all_issued_o,
  output logic                   all_returned_o
);
  import mem_bridge_pkg::*;

  // Beats still to send and responses still expected.
  beats_t issue_left_q;
  beats_t resp_left_q;

  // Both counts start from the burst length when a command is taken.
  // Each grant removes one beat and each response removes one expected answer.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      issue_left_q <= '0;
      resp_left_q  <= '0;
    end else if (load_i) begin
      issue_left_q <= beats_i;
      resp_left_q  <= beats_i;
    end else begin
      if (issue_i) begin
        issue_left_q <= issue_left_q - beats_t'(1);
      end
      if (return_i) begin
        resp_left_q <= resp_left_q - beats_t'(1);
      end
    end
  end

  assign last_issue_o   = (issue_left_q == beats_t'(1));
  assign all_issued_o   = (issue_left_q == '0);
  assign all_returned_o = (resp_left_q == '0);

  // A bank must never answer more often than it was granted for this path.
  assert property (@(posedge clk_i) disable iff (!rst_n_i) return_i |-> !all_returned_o)
    else $error("beat_counter: response with no beat outstanding");

endmodule

`default_nettype wire

/* hw/route_fifo.sv */
// One-bit route FIFO that records the owner of each outstanding bank request.
`timescale 1ns/1ns
`default_nettype none

module route_fifo #(
  // Number of entries.
  // It must cover the requests a bank can hold in flight.
  parameter int unsigned Depth = 2
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic push_i,
  input  logic data_i,
  input  logic pop_i,
  output logic head_o,
  output logic full_o,
  output logic empty_o
);
  import mem_bridge_pkg::*;

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  logic [Depth-1:0] mem_q;
  logic [PtrW-1:0]  wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0]  count_q;

  assign head_o  = mem_q[rd_ptr_q];
  assign full_o  = (count_q == CntW'(Depth));
  assign empty_o = (count_q == '0);

  // Pointers wrap at Depth so any depth works, not only powers of two.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + PtrW'(1);
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + PtrW'(1);
      end
      // Push and pop in one cycle leave the fill level as it is.
      if (push_i && !pop_i) begin
        count_q <= count_q + CntW'(1);
      end else if (pop_i && !push_i) begin
        count_q <= count_q - CntW'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) !(push_i && full_o))
    else $error("route_fifo: push while full");

  assert property (@(posedge clk_i) disable iff (!rst_n_i) !(pop_i && empty_o))
    else $error("route_fifo: pop while empty");

endmodule

`default_nettype wire

/* hw/burst_sequencer.sv */
// Burst sequencer FSM that splits a burst command into per-bank word requests.
`include "mem_bridge_cfg.svh"
`timescale 1ns/1ns
`default_nettype none

module burst_sequencer #(
  // Set on the write path, where it drives write data and hands out wdata_ready.
  parameter bit IsWrite = 1'b0
) (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  logic                                        cmd_valid_i,
  input  mem_bridge_pkg::addr_t                       cmd_addr_i,
  input  mem_bridge_pkg::beats_t                      cmd_beats_i,
  output logic                                        cmd_ready_o,
  input  mem_bridge_pkg::data_t                       wdata_i,
  input  mem_bridge_pkg::strb_t                       strb_i,
  output logic                                        wdata_ready_o,
  output logic                  [`MB_NUM_BANKS-1:0]   req_o,
  output mem_bridge_pkg::addr_t [`MB_NUM_BANKS-1:0]   addr_o,
  output mem_bridge_pkg::data_t [`MB_NUM_BANKS-1:0]   wdata_o,
  output mem_bridge_pkg::strb_t [`MB_NUM_BANKS-1:0]   strb_o,
  input  logic                  [`MB_NUM_BANKS-1:0]   gnt_i,
  input  logic                  [`MB_NUM_BANKS-1:0]   rvalid_i,
  input  mem_bridge_pkg::data_t [`MB_NUM_BANKS-1:0]   rdata_i,
  output logic                                        rvalid_o,
  output mem_bridge_pkg::data_t                       rdata_o,
  output logic                                        done_o,
  output logic                                        busy_o
);
  import mem_bridge_pkg::*;

  localparam int unsigned NumBanks  = `MB_NUM_BANKS;
  localparam int unsigned WordBytes = `MB_DATA_W / 8;
  localparam int unsigned SelLsb    = $clog2(WordBytes);

  seq_state_e state_q, state_d;
  addr_t      addr_q;
  bank_sel_t  bank_sel;
  logic       accept, issuing, beat_gnt;
  logic       last_issue, all_issued, all_returned;

  assign cmd_ready_o = (state_q == IDLE);
  assign busy_o      = (state_q != IDLE);
  assign accept      = cmd_valid_i && cmd_ready_o;

  // The word-address bits above the byte offset pick the bank of the current beat.
  assign bank_sel = addr_q[SelLsb +: $bits(bank_sel_t)];
  assign issuing  = (state_q == ISSUE) && !all_issued;
  assign req_o    = issuing ? (NumBanks'(1) << bank_sel) : '0;
  assign beat_gnt = |(gnt_i & req_o);

  // Payload goes to every bank, only the requested one looks at it.
  assign addr_o        = {NumBanks{addr_q}};
  assign wdata_o       = IsWrite ? {NumBanks{wdata_i}} : '0;
  assign strb_o        = IsWrite ? {NumBanks{strb_i}} : '0;
  assign wdata_ready_o = IsWrite && beat_gnt;

  // Banks answer in grant order and never two at once for one path.
  always_comb begin
    rvalid_o = |rvalid_i;
    rdata_o  = '0;
    for (int b = 0; b < NumBanks; b++) begin
      if (rvalid_i[b]) begin
        rdata_o = rdata_i[b];
      end
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = ISSUE;
        end
      end
      ISSUE: begin
        if (beat_gnt && last_issue) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        if (all_returned) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // Done marks the cycle after the last response of the burst.
  assign done_o = (state_q == DRAIN) && all_returned;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // The beat address steps one word after each granted beat.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= cmd_addr_i;
    end else if (beat_gnt) begin
      addr_q <= addr_q + addr_t'(WordBytes);
    end
  end

  beat_counter i_beat_counter (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .load_i         ( accept       ),
    .beats_i        ( cmd_beats_i  ),
    .issue_i        ( beat_gnt     ),
    .return_i       ( rvalid_o     ),
    .last_issue_o   ( last_issue   ),
    .all_issued_o   ( all_issued   ),
    .all_returned_o ( all_returned )
  );

  // The fixed bank latency keeps responses of one path apart.
  assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(rvalid_i))
    else $error("burst_sequencer: two banks answered in one cycle");

  // A command from outside must carry a legal burst length.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
      accept |-> (cmd_beats_i != '0) && (cmd_beats_i <= beats_t'(`MB_MAX_BEATS)))
    else $error("burst_sequencer: burst length out of range");

endmodule

`default_nettype wire

/* hw/bank_arbiter.sv */
// Per-bank round-robin arbiter between read and write paths with response steering.
`include "mem_bridge_cfg.svh"
`timescale 1ns/1ns
`default_nettype none

module bank_arbiter (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  rd_req_i,
  input  logic                  wr_req_i,
  output logic                  rd_gnt_o,
  output logic                  wr_gnt_o,
  input  mem_bridge_pkg::addr_t rd_addr_i,
  input  mem_bridge_pkg::addr_t wr_addr_i,
  input  mem_bridge_pkg::data_t wr_wdata_i,
  input  mem_bridge_pkg::strb_t wr_strb_i,
  output logic                  mem_req_o,
  input  logic                  mem_gnt_i,
  output mem_bridge_pkg::addr_t mem_addr_o,
  output mem_bridge_pkg::data_t mem_wdata_o,
  output mem_bridge_pkg::strb_t mem_strb_o,
  output logic                  mem_we_o,
  input  logic                  mem_rvalid_i,
  output logic                  rd_rvalid_o,
  output logic                  wr_rvalid_o
);
  import mem_bridge_pkg::*;

  // Round-robin pointer.
  // A low pointer favours the read path.
  logic rr_q;
  logic pick_wr;
  logic route_head;

  // A lone requester wins at once, a contested cycle follows the pointer.
  assign pick_wr   = wr_req_i && (!rd_req_i || rr_q);
  assign mem_req_o = rd_req_i || wr_req_i;
  assign rd_gnt_o  = mem_gnt_i && rd_req_i && !pick_wr;
  assign wr_gnt_o  = mem_gnt_i && pick_wr;

  // Only the write path carries data and strobes, reads present zero strobes.
  assign mem_addr_o  = pick_wr ? wr_addr_i : rd_addr_i;
  assign mem_wdata_o = wr_wdata_i;
  assign mem_strb_o  = pick_wr ? wr_strb_i : strb_t'('0);
  assign mem_we_o    = pick_wr;

  // The pointer only moves when both paths wanted the bank and one got it.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q <= 1'b0;
    end else if (rd_req_i && wr_req_i && mem_gnt_i) begin
      rr_q <= !rr_q;
    end
  end

  // A set bit at the head means the next bank response belongs to the write path.
  route_fifo #(
    .Depth ( `MB_RESP_DEPTH + 1 )
  ) i_route_fifo (
    .clk_i   ( clk_i                  ),
    .rst_n_i ( rst_n_i                ),
    .push_i  ( mem_req_o && mem_gnt_i ),
    .data_i  ( pick_wr                ),
    .pop_i   ( mem_rvalid_i           ),
    .head_o  ( route_head             ),
    .full_o  (                        ),
    .empty_o (                        )
  );

  assign rd_rvalid_o = mem_rvalid_i && !route_head;
  assign wr_rvalid_o = mem_rvalid_i && route_head;

  // The bank answers each grant exactly after the fixed latency.
  // Route steering depends on it.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_rvalid_i |-> $past(mem_req_o && mem_gnt_i, `MB_RESP_DEPTH))
    else $error("bank_arbiter: bank response off the fixed latency");

endmodule

`default_nettype wire

/* hw/mem_bridge.sv */
// Top level of the banked SRAM bridge with separate read and write burst paths.
`include "mem_bridge_cfg.svh"
`timescale 1ns/1ns
`default_nettype none

module mem_bridge (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic                                      rd_cmd_valid_i,
  input  mem_bridge_pkg::addr_t                     rd_cmd_addr_i,
  input  mem_bridge_pkg::beats_t                    rd_cmd_beats_i,
  output logic                                      rd_cmd_ready_o,
  output logic                                      rd_rvalid_o,
  output mem_bridge_pkg::data_t                     rd_rdata_o,
  output logic                                      rd_done_o,
  input  logic                                      wr_cmd_valid_i,
  input  mem_bridge_pkg::addr_t                     wr_cmd_addr_i,
  input  mem_bridge_pkg::beats_t                    wr_cmd_beats_i,
  output logic                                      wr_cmd_ready_o,
  input  mem_bridge_pkg::data_t                     wr_wdata_i,
  input  mem_bridge_pkg::strb_t                     wr_strb_i,
  output logic                                      wr_wdata_ready_o,
  output logic                                      wr_done_o,
  output logic                                      busy_o,
  output logic                  [`MB_NUM_BANKS-1:0] mem_req_o,
  output mem_bridge_pkg::addr_t [`MB_NUM_BANKS-1:0] mem_addr_o,
  output mem_bridge_pkg::data_t [`MB_NUM_BANKS-1:0] mem_wdata_o,
  output mem_bridge_pkg::strb_t [`MB_NUM_BANKS-1:0] mem_strb_o,
  output logic                  [`MB_NUM_BANKS-1:0] mem_we_o,
  input  logic                  [`MB_NUM_BANKS-1:0] mem_gnt_i,
  input  logic                  [`MB_NUM_BANKS-1:0] mem_rvalid_i,
  input  mem_bridge_pkg::data_t [`MB_NUM_BANKS-1:0] mem_rdata_i
);
  import mem_bridge_pkg::*;

  // Per-bank links between the sequencers and the arbiters.
  logic  [`MB_NUM_BANKS-1:0] rd_req, wr_req;
  logic  [`MB_NUM_BANKS-1:0] rd_gnt, wr_gnt;
  logic  [`MB_NUM_BANKS-1:0] rd_rvalid, wr_rvalid;
  addr_t [`MB_NUM_BANKS-1:0] rd_addr, wr_addr;
  data_t [`MB_NUM_BANKS-1:0] wr_data;
  strb_t [`MB_NUM_BANKS-1:0] wr_strb;
  logic                      rd_busy, wr_busy;

  assign busy_o = rd_busy || wr_busy;

  // Read path.
  // It has no write payload, so its data inputs are tied off.
  burst_sequencer #(
    .IsWrite ( 1'b0 )
  ) i_rd_sequencer (
    .clk_i         ( clk_i          ),
    .rst_n_i       ( rst_n_i        ),
    .cmd_valid_i   ( rd_cmd_valid_i ),
    .cmd_addr_i    ( rd_cmd_addr_i  ),
    .cmd_beats_i   ( rd_cmd_beats_i ),
    .cmd_ready_o   ( rd_cmd_ready_o ),
    .wdata_i       ( '0             ),
    .strb_i        ( '0             ),
    .wdata_ready_o (                ),
    .req_o         ( rd_req         ),
    .addr_o        ( rd_addr        ),
    .wdata_o       (                ),
    .strb_o        (                ),
    .gnt_i         ( rd_gnt         ),
    .rvalid_i      ( rd_rvalid      ),
    .rdata_i       ( mem_rdata_i    ),
    .rvalid_o      ( rd_rvalid_o    ),
    .rdata_o       ( rd_rdata_o     ),
    .done_o        ( rd_done_o      ),
    .busy_o        ( rd_busy        )
  );

  // Write path.
  // Its bank responses are only acknowledgements and count toward done.
  burst_sequencer #(
    .IsWrite ( 1'b1 )
  ) i_wr_sequencer (
    .clk_i         ( clk_i            ),
    .rst_n_i       ( rst_n_i          ),
    .cmd_valid_i   ( wr_cmd_valid_i   ),
    .cmd_addr_i    ( wr_cmd_addr_i    ),
    .cmd_beats_i   ( wr_cmd_beats_i   ),
    .cmd_ready_o   ( wr_cmd_ready_o   ),
    .wdata_i       ( wr_wdata_i       ),
    .strb_i        ( wr_strb_i        ),
    .wdata_ready_o ( wr_wdata_ready_o ),
    .req_o         ( wr_req           ),
    .addr_o        ( wr_addr          ),
    .wdata_o       ( wr_data          ),
    .strb_o        ( wr_strb          ),
    .gnt_i         ( wr_gnt           ),
    .rvalid_i      ( wr_rvalid        ),
    .rdata_i       ( mem_rdata_i      ),
    .rvalid_o      (                  ),
    .rdata_o       (                  ),
    .done_o        ( wr_done_o        ),
    .busy_o        ( wr_busy          )
  );

  // One arbiter per bank lets reads pass queued writes on the other bank.
  for (genvar b = 0; b < `MB_NUM_BANKS; b++) begin : g_bank
    bank_arbiter i_bank_arbiter (
      .clk_i        ( clk_i           ),
      .rst_n_i      ( rst_n_i         ),
      .rd_req_i     ( rd_req[b]       ),
      .wr_req_i     ( wr_req[b]       ),
      .rd_gnt_o     ( rd_gnt[b]       ),
      .wr_gnt_o     ( wr_gnt[b]       ),
      .rd_addr_i    ( rd_addr[b]      ),
      .wr_addr_i    ( wr_addr[b]      ),
      .wr_wdata_i   ( wr_data[b]      ),
      .wr_strb_i    ( wr_strb[b]      ),
      .mem_req_o    ( mem_req_o[b]    ),
      .mem_gnt_i    ( mem_gnt_i[b]    ),
      .mem_addr_o   ( mem_addr_o[b]   ),
      .mem_wdata_o  ( mem_wdata_o[b]  ),
      .mem_strb_o   ( mem_strb_o[b]   ),
      .mem_we_o     ( mem_we_o[b]     ),
      .mem_rvalid_i ( mem_rvalid_i[b] ),
      .rd_rvalid_o  ( rd_rvalid[b]    ),
      .wr_rvalid_o  ( wr_rvalid[b]    )
    );
  end

endmodule

`default_nettype wire

/* tests/tb_mem_bridge.sv */
// Directed testbench for the memory bridge with bank models, a grant stall LFSR and compare tasks.
`include "mem_bridge_cfg.svh"
`timescale 1ns/1ns
`default_nettype none

module tb_mem_bridge;
  import mem_bridge_pkg::*;

  localparam int NumBanks      = `MB_NUM_BANKS;
  localparam int RespDepth     = `MB_RESP_DEPTH;
  localparam int NumWords      = 1 << (`MB_ADDR_W - 2);
  localparam int BankWords     = NumWords / NumBanks;
  localparam int IdxShift      = 2 + $clog2(NumBanks);
  localparam int TimeoutCycles = 2000;

  logic clk_i = 1'b0;
  logic rst_n_i;
  logic rd_cmd_valid_i, wr_cmd_valid_i;
  addr_t rd_cmd_addr_i, wr_cmd_addr_i;
  beats_t rd_cmd_beats_i, wr_cmd_beats_i;
  logic rd_cmd_ready_o, wr_cmd_ready_o, rd_rvalid_o, rd_done_o, wr_done_o, busy_o;
  logic wr_wdata_ready_o;
  data_t rd_rdata_o;
  data_t wr_wdata_i = '0;
  strb_t wr_strb_i = '0;
  logic  [NumBanks-1:0] mem_req_o, mem_we_o;
  addr_t [NumBanks-1:0] mem_addr_o;
  data_t [NumBanks-1:0] mem_wdata_o;
  strb_t [NumBanks-1:0] mem_strb_o;
  logic  [NumBanks-1:0] mem_gnt_i = '0;
  logic  [NumBanks-1:0] mem_rvalid_i;
  data_t [NumBanks-1:0] mem_rdata_i;

  // Bank storage, response pipeline and the stall source belong to the bank model.
  data_t          bank_mem [NumBanks][BankWords];
  logic [RespDepth-1:0] pipe_v [NumBanks] = '{default: '0};
  data_t          pipe_d [NumBanks][RespDepth] = '{default: '0};
  logic [16:0]    lfsr_q = 17'd82694;
  logic           filled = 1'b0;
  logic           stall_on = 1'b0;

  // Write beats of the current burst and the feeder position.
  data_t wdat [`MB_MAX_BEATS+1];
  strb_t wstb [`MB_MAX_BEATS+1];
  logic  wr_start = 1'b0;
  int    wr_pos = 0;

  // Reference memory and what the monitor collected.
  data_t ref_mem [NumWords];
  data_t rd_exp [$];
  data_t rd_log [$];
  int    rd_base, rd_target, wr_target;
  int    rd_done_cnt = 0;
  int    wr_done_cnt = 0;

  always #4 clk_i = ~clk_i;

  mem_bridge dut (
    .clk_i, .rst_n_i,
    .rd_cmd_valid_i, .rd_cmd_addr_i, .rd_cmd_beats_i, .rd_cmd_ready_o,
    .rd_rvalid_o, .rd_rdata_o, .rd_done_o,
    .wr_cmd_valid_i, .wr_cmd_addr_i, .wr_cmd_beats_i, .wr_cmd_ready_o,
    .wr_wdata_i, .wr_strb_i, .wr_wdata_ready_o, .wr_done_o, .busy_o,
    .mem_req_o, .mem_addr_o, .mem_wdata_o, .mem_strb_o, .mem_we_o,
    .mem_gnt_i, .mem_rvalid_i, .mem_rdata_i
  );

  // Initial memory contents differ for every word address.
  function automatic data_t fill_word(input int word);
    return data_t'(word) * 32'h9E37_79B1 ^ 32'h5A5A_0F0F;
  endfunction

  // Byte-wise merge of new data into an old word under the strobes.
  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input strb_t s);
    data_t res;
    res = old_w;
    for (int k = 0; k < `MB_DATA_W / 8; k++) begin
      if (s[k]) res[8*k +: 8] = new_w[8*k +: 8];
    end
    return res;
  endfunction

  // Fibonacci LFSR with taps 17 and 14.
  // The new low bit is the bit taken.
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    logic fb;
    fb = s[16] ^ s[13];
    return {s[15:0], fb};
  endfunction

  // The bank model grants on the gnt level and answers every grant after the fixed latency.
  always @(posedge clk_i) begin
    int idx;
    logic granted;
    if (!rst_n_i) begin
      if (!filled) begin
        for (int w = 0; w < NumWords; w++) bank_mem[w % NumBanks][w / NumBanks] = fill_word(w);
        filled = 1'b1;
      end
      mem_gnt_i <= '0;
      for (int b = 0; b < NumBanks; b++) pipe_v[b] <= '0;
    end else begin
      for (int b = 0; b < NumBanks; b++) begin
        granted = mem_req_o[b] && mem_gnt_i[b];
        idx = int'(mem_addr_o[b]) >> IdxShift;
        for (int i = 0; i < RespDepth - 1; i++) begin
          pipe_v[b][i] <= pipe_v[b][i+1];
          pipe_d[b][i] <= pipe_d[b][i+1];
        end
        pipe_v[b][RespDepth-1] <= granted;
        // Reads return the word as stored at the grant, writes return zero.
        pipe_d[b][RespDepth-1] <= (granted && !mem_we_o[b]) ? bank_mem[b][idx] : '0;
        if (granted && mem_we_o[b]) begin
          bank_mem[b][idx] = merge_bytes(bank_mem[b][idx], mem_wdata_o[b], mem_strb_o[b]);
        end
        if (stall_on) begin
          lfsr_q = lfsr_next(lfsr_q);
          mem_gnt_i[b] <= lfsr_q[0];
        end else begin
          mem_gnt_i[b] <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int b = 0; b < NumBanks; b++) begin
      mem_rvalid_i[b] = pipe_v[b][0];
      mem_rdata_i[b]  = pipe_d[b][0];
    end
  end

  // Write source. It holds each beat until the DUT takes it with wr_wdata_ready_o.
  always @(posedge clk_i) begin
    if (wr_start) begin
      wr_pos     <= 1;
      wr_wdata_i <= wdat[0];
      wr_strb_i  <= wstb[0];
    end else if (wr_wdata_ready_o) begin
      wr_pos     <= wr_pos + 1;
      wr_wdata_i <= wdat[wr_pos];
      wr_strb_i  <= wstb[wr_pos];
    end
  end

  // Monitor of read data and done pulses.
  always @(posedge clk_i) begin
    if (rd_rvalid_o) rd_log.push_back(rd_rdata_o);
    if (rd_done_o) rd_done_cnt <= rd_done_cnt + 1;
    if (wr_done_o) wr_done_cnt <= wr_done_cnt + 1;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic fill_beats(input data_t base, input strb_t strb, input int n);
    for (int i = 0; i <= `MB_MAX_BEATS; i++) begin
      wdat[i] = (i < n) ? base ^ data_t'(i * 32'h0101_0101) : '0;
      wstb[i] = strb;
    end
  endtask

  // Issues a read command, a write command or both in the same cycle.
  task automatic send_cmds(input bit do_rd, input addr_t ra, input int rn,
                           input bit do_wr, input addr_t wa, input int wn);
    @(negedge clk_i);
    if (do_rd) check_bit("rd_cmd_ready_o", rd_cmd_ready_o, 1'b1);
    if (do_wr) check_bit("wr_cmd_ready_o", wr_cmd_ready_o, 1'b1);
    // Expected read data comes from the reference before the write lands in it.
    if (do_rd) begin
      rd_exp.delete();
      rd_base   = rd_log.size();
      rd_target = rd_done_cnt + 1;
      for (int i = 0; i < rn; i++) rd_exp.push_back(ref_mem[(int'(ra) >> 2) + i]);
    end
    if (do_wr) begin
      wr_target = wr_done_cnt + 1;
      for (int i = 0; i < wn; i++) begin
        ref_mem[(int'(wa) >> 2) + i] = merge_bytes(ref_mem[(int'(wa) >> 2) + i], wdat[i], wstb[i]);
      end
    end
    @(posedge clk_i);
    wr_start <= do_wr;
    @(posedge clk_i);
    wr_start       <= 1'b0;
    rd_cmd_valid_i <= do_rd;
    rd_cmd_addr_i  <= ra;
    rd_cmd_beats_i <= beats_t'(rn);
    wr_cmd_valid_i <= do_wr;
    wr_cmd_addr_i  <= wa;
    wr_cmd_beats_i <= beats_t'(wn);
    @(posedge clk_i);
    rd_cmd_valid_i <= 1'b0;
    wr_cmd_valid_i <= 1'b0;
    @(negedge clk_i);
    check_bit("busy_o", busy_o, 1'b1);
    if (do_rd) check_bit("rd_cmd_ready_o", rd_cmd_ready_o, 1'b0);
    if (do_wr) check_bit("wr_cmd_ready_o", wr_cmd_ready_o, 1'b0);
  endtask

  task automatic wait_done(input bit is_wr);
    int cycles;
    cycles = 0;
    while ((is_wr ? wr_done_cnt : rd_done_cnt) < (is_wr ? wr_target : rd_target)) begin
      if (cycles == TimeoutCycles) begin
        abort_run(is_wr ? "Timeout: the write burst never pulsed wr_done_o."
                        : "Timeout: the read burst never pulsed rd_done_o.");
      end
      @(negedge clk_i);
      cycles++;
    end
  endtask

  // A few quiet cycles show that each done pulsed only once and the bridge is idle.
  task automatic check_idle();
    repeat (4) @(negedge clk_i);
    if (rd_done_cnt != rd_target) abort_run("rd_done_o pulsed more than once for one burst.");
    if (wr_done_cnt != wr_target) abort_run("wr_done_o pulsed more than once for one burst.");
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("rd_cmd_ready_o", rd_cmd_ready_o, 1'b1);
    check_bit("wr_cmd_ready_o", wr_cmd_ready_o, 1'b1);
  endtask

  task automatic check_reads();
    if (rd_log.size() - rd_base != rd_exp.size()) begin
      abort_run($sformatf("The read burst returned %0d beats instead of %0d.",
                          rd_log.size() - rd_base, rd_exp.size()));
    end
    for (int i = 0; i < rd_exp.size(); i++) begin
      check_data($sformatf("rd_rdata_o[beat %0d]", i), rd_log[rd_base + i], rd_exp[i]);
    end
  endtask

  task automatic write_then_read(input addr_t a, input int n, input data_t base, input strb_t s);
    fill_beats(base, s, n);
    send_cmds(1'b0, '0, 0, 1'b1, a, n);
    wait_done(1'b1);
    check_idle();
    send_cmds(1'b1, a, n, 1'b0, '0, 0);
    wait_done(1'b0);
    check_reads();
    check_idle();
  endtask

  task automatic test_concurrent();
    // The read sees the old contents while the write fills another region.
    fill_beats(32'h7E57_0000, 4'hF, 8);
    send_cmds(1'b1, 16'h0300, 8, 1'b1, 16'h0400, 8);
    wait_done(1'b0);
    wait_done(1'b1);
    check_reads();
    check_idle();
    send_cmds(1'b1, 16'h0400, 8, 1'b0, '0, 0);
    wait_done(1'b0);
    check_reads();
    check_idle();
  endtask

  initial begin
    rst_n_i        = 1'b0;
    rd_cmd_valid_i = 1'b0;
    rd_cmd_addr_i  = '0;
    rd_cmd_beats_i = '0;
    wr_cmd_valid_i = 1'b0;
    wr_cmd_addr_i  = '0;
    wr_cmd_beats_i = '0;
    rd_target      = 0;
    wr_target      = 0;
    for (int w = 0; w < NumWords; w++) ref_mem[w] = fill_word(w);
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("mem_req_o", |mem_req_o, 1'b0);
    check_bit("rd_rvalid_o", rd_rvalid_o, 1'b0);
    check_bit("wr_wdata_ready_o", wr_wdata_ready_o, 1'b0);
    check_bit("rd_done_o", rd_done_o, 1'b0);
    check_bit("wr_done_o", wr_done_o, 1'b0);
    check_bit("rd_cmd_ready_o", rd_cmd_ready_o, 1'b1);
    check_bit("wr_cmd_ready_o", wr_cmd_ready_o, 1'b1);
    write_then_read(16'h0010, 1, 32'hC0FF_EE01, 4'hF);
    // Starting on an odd word puts the first beat in bank 1.
    write_then_read(16'h0104, 8, 32'hA500_1200, 4'hF);
    write_then_read(16'h0200, 4, 32'h1122_3344, 4'b0101);
    test_concurrent();
    stall_on = 1'b1;
    write_then_read(16'h0504, 16, 32'h5AA5_0001, 4'hF);
    stall_on = 1'b0;
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+hw
hw/mem_bridge_pkg.sv
hw/beat_counter.sv
hw/route_fifo.sv
hw/burst_sequencer.sv
hw/bank_arbiter.sv
hw/mem_bridge.sv
tests/tb_mem_bridge.sv

/* run.sh */
#!/bin/sh
# Builds the memory bridge testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f flist.f --top-module tb_mem_bridge -o tb_mem_bridge
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_mem_bridge > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
